// ==== verilog/mfp_pkg.sv ====
// shared definitions for the mfp peripheral
// register map, timer modes, prescaler ratios and interrupt numbers

package mfp_pkg;

	// cpu register addresses, also used as the bus opcode
	typedef enum logic [4:0] {
		REG_GPIP  = 5'h00,
		REG_AER   = 5'h01,
		REG_DDR   = 5'h02,
		REG_IERA  = 5'h03,
		REG_IERB  = 5'h04,
		REG_IPRA  = 5'h05,
		REG_IPRB  = 5'h06,
		REG_ISRA  = 5'h07,
		REG_ISRB  = 5'h08,
		REG_IMRA  = 5'h09,
		REG_IMRB  = 5'h0a,
		REG_VR    = 5'h0b,
		REG_TACR  = 5'h0c,
		REG_TBCR  = 5'h0d,
		REG_TCDCR = 5'h0e,
		REG_TADR  = 5'h0f,
		REG_TBDR  = 5'h10,
		REG_TCDR  = 5'h11,
		REG_TDDR  = 5'h12,
		REG_TSR   = 5'h16,
		REG_UDR   = 5'h17
	} mfp_reg_e;

	// timer control field, codes 9..15 act as stop
	typedef enum logic [3:0] {
		TM_STOP      = 4'd0,
		TM_DELAY_4   = 4'd1,
		TM_DELAY_10  = 4'd2,
		TM_DELAY_16  = 4'd3,
		TM_DELAY_50  = 4'd4,
		TM_DELAY_64  = 4'd5,
		TM_DELAY_100 = 4'd6,
		TM_DELAY_200 = 4'd7,
		TM_EVENT     = 4'd8
	} timer_mode_e;

	// clk_ext ticks per count in each delay mode
	function automatic logic [7:0] prescale_div(input timer_mode_e mode);
		case (mode)
			TM_DELAY_4:   return 8'd4;
			TM_DELAY_10:  return 8'd10;
			TM_DELAY_16:  return 8'd16;
			TM_DELAY_50:  return 8'd50;
			TM_DELAY_64:  return 8'd64;
			TM_DELAY_100: return 8'd100;
			TM_DELAY_200: return 8'd200;
			default:      return 8'd1;
		endcase
	endfunction

	// interrupt source numbers, higher number wins
	localparam logic [3:0] IRQ_TIMER_A = 4'd13;
	localparam logic [3:0] IRQ_TIMER_B = 4'd8;
	localparam logic [3:0] IRQ_DMA     = 4'd7;
	localparam logic [3:0] IRQ_ACIA    = 4'd6;
	localparam logic [3:0] IRQ_TIMER_C = 4'd5;
	localparam logic [3:0] IRQ_TIMER_D = 4'd4;
	localparam logic [3:0] IRQ_BLITTER = 4'd3;

endpackage

// ==== verilog/mfp_timer.sv ====
// mfp timer: 8-bit down counter with prescaler and reload
// delay mode counts clk_ext ticks, event mode counts t_i edges

`timescale 1ns/10ps

module mfp_timer import mfp_pkg::*; #(
	parameter bit HAS_EVENT = 1'b1
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       xclk_i,
	input  logic       t_i,
	input  logic [3:0] ctrl_i,
	input  logic       ctrl_we_i,
	input  logic [7:0] dat_i,
	input  logic       dat_we_i,
	output logic [3:0] ctrl_o,
	output logic [7:0] dat_o,
	output logic       done_o
);

	timer_mode_e mode;
	logic [7:0]  presc;
	logic [7:0]  div;
	logic [2:0]  xclk_sync;
	logic [2:0]  t_sync;
	logic [7:0]  reload;
	logic [7:0]  count;
	logic        xtick;
	logic        t_edge;
	logic        is_delay;
	logic        is_event;
	logic        running;
	logic        presc_wrap;
	logic        dec;

	// rising edges seen after two sync stages
	assign xtick  = xclk_sync[1] & ~xclk_sync[2];
	assign t_edge = t_sync[1] & ~t_sync[2];

	assign is_delay = mode inside {[TM_DELAY_4:TM_DELAY_200]};
	assign is_event = HAS_EVENT && (mode == TM_EVENT);
	assign running  = is_delay || is_event;

	assign div        = prescale_div(mode);
	assign presc_wrap = (presc == div - 8'd1);

	assign dec = (is_delay && xtick && presc_wrap) || (is_event && t_edge);

	always_ff @(posedge clk) begin
		if (reset) begin
			mode      <= TM_STOP;
			presc     <= 8'd0;
			xclk_sync <= 3'b000;
			t_sync    <= 3'b000;
			count     <= 8'd0;
			done_o    <= 1'b0;
		end else begin
			xclk_sync <= {xclk_sync[1:0], xclk_i};
			t_sync    <= {t_sync[1:0], t_i};

			// terminal count is the step from 1 to 0
			done_o <= dec && (count == 8'd1);

			if (ctrl_we_i)
				mode <= timer_mode_e'(ctrl_i);

			// prescaler only runs in delay mode
			if (!is_delay)
				presc <= 8'd0;
			else if (xtick)
				presc <= presc_wrap ? 8'd0 : presc + 8'd1;

			// a running timer picks up new data at its next reload
			if (dat_we_i && !running)
				count <= dat_i;
			else if (dec)
				count <= (count == 8'd1) ? reload : count - 8'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (dat_we_i)
			reload <= dat_i;
	end

	assign ctrl_o = mode;
	assign dat_o  = count;

	// reload happens on a single decrement, so done cannot repeat back to back
	done_single: assert property (@(posedge clk) disable iff (reset)
		done_o |=> !done_o);

endmodule

// ==== verilog/mfp_irq_ctrl.sv ====
// mfp interrupt controller for 16 sources
// edge capture, ier/ipr/isr/imr registers, priority and vectored acknowledge

`timescale 1ns/10ps

module mfp_irq_ctrl import mfp_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        we_i,
	input  mfp_reg_e    addr_i,
	input  logic [7:0]  din_i,
	input  logic [7:0]  vr_i,
	// timer order is d, c, b, a from msb down
	input  logic [3:0]  timer_done_i,
	input  logic        dma_irq_i,
	input  logic        acia_irq_i,
	input  logic        blitter_irq_i,
	input  logic        iack_i,
	output logic        irq_o,
	output logic [7:0]  vec_o,
	output logic [15:0] ier_o,
	output logic [15:0] ipr_o,
	output logic [15:0] isr_o,
	output logic [15:0] imr_o
);

	logic [15:0] ier;
	logic [15:0] ipr;
	logic [15:0] isr;
	logic [15:0] imr;
	logic [15:0] ipr_n;
	logic [15:0] isr_n;
	logic [15:0] set_vec;
	logic [15:0] pend_map;
	logic [15:0] act_map;
	logic [1:0]  dma_s;
	logic [1:0]  acia_s;
	logic [1:0]  blit_s;
	logic [3:0]  hp;
	logic [3:0]  ha;
	logic [7:0]  vec_q;
	logic        iack_d;
	logic        pend_any;
	logic        ack;

	function automatic logic [3:0] highest_set(input logic [15:0] map);
		logic [3:0] num;
		num = 4'd0;
		for (int i = 0; i < 16; i++) begin
			if (map[i])
				num = 4'(i);
		end
		return num;
	endfunction

	assign pend_map = ipr & imr;
	// in-service bits block lower sources until cleared
	assign act_map  = (ipr | isr) & imr;
	assign hp       = highest_set(pend_map);
	assign ha       = highest_set(act_map);
	assign pend_any = |pend_map;

	assign irq_o = pend_any && (hp == ha);
	assign ack   = iack_i && !iack_d;

	always_comb begin
		set_vec = 16'h0000;
		set_vec[IRQ_TIMER_A] = timer_done_i[0];
		set_vec[IRQ_TIMER_B] = timer_done_i[1];
		set_vec[IRQ_TIMER_C] = timer_done_i[2];
		set_vec[IRQ_TIMER_D] = timer_done_i[3];
		set_vec[IRQ_DMA]     = dma_s[0] & ~dma_s[1];
		set_vec[IRQ_ACIA]    = acia_s[0] & ~acia_s[1];
		set_vec[IRQ_BLITTER] = blit_s[0] & ~blit_s[1];
	end

	always_comb begin
		ipr_n = ipr;
		isr_n = isr;
		if (ack && pend_any) begin
			ipr_n[hp] = 1'b0;
			if (vr_i[3])
				isr_n[hp] = 1'b1;
		end
		ipr_n = ipr_n | (set_vec & ier);
		// cpu writes come last, zero bits clear
		if (we_i) begin
			case (addr_i)
				REG_IERA, REG_IPRA: ipr_n[15:8] = ipr_n[15:8] & din_i;
				REG_IERB, REG_IPRB: ipr_n[7:0]  = ipr_n[7:0] & din_i;
				REG_ISRA:           isr_n[15:8] = isr_n[15:8] & din_i;
				REG_ISRB:           isr_n[7:0]  = isr_n[7:0] & din_i;
				default:            ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ier    <= 16'h0000;
			ipr    <= 16'h0000;
			isr    <= 16'h0000;
			imr    <= 16'h0000;
			dma_s  <= 2'b00;
			acia_s <= 2'b00;
			blit_s <= 2'b00;
			iack_d <= 1'b0;
		end else begin
			dma_s  <= {dma_s[0], dma_irq_i};
			acia_s <= {acia_s[0], acia_irq_i};
			blit_s <= {blit_s[0], blitter_irq_i};
			iack_d <= iack_i;
			ipr    <= ipr_n;
			isr    <= isr_n;
			if (we_i && addr_i == REG_IERA)
				ier[15:8] <= din_i;
			if (we_i && addr_i == REG_IERB)
				ier[7:0] <= din_i;
			if (we_i && addr_i == REG_IMRA)
				imr[15:8] <= din_i;
			if (we_i && addr_i == REG_IMRB)
				imr[7:0] <= din_i;
		end
	end

	// vector held one cycle behind so it stays stable during the iack read
	always_ff @(posedge clk) begin
		vec_q <= {vr_i[7:4], hp};
	end

	assign vec_o = vec_q;
	assign ier_o = ier;
	assign ipr_o = ipr;
	assign isr_o = isr;
	assign imr_o = imr;

	// the cpu should only acknowledge while a request is presented
	ack_has_pending: assert property (@(posedge clk) disable iff (reset)
		$rose(iack_i) |-> pend_any);

endmodule

// ==== verilog/mfp_uart_fifo.sv ====
// transmit byte FIFO between the cpu and the io controller
// cpu pushes through the data register, rising strobe edges pop

`timescale 1ns/10ps

module mfp_uart_fifo #(
	parameter int FIFO_ADDR_BITS = 4
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       push_i,
	input  logic [7:0] data_i,
	input  logic       strobe_i,
	output logic       avail_o,
	output logic       full_o,
	output logic [7:0] data_o
);

	localparam int DEPTH = 1 << FIFO_ADDR_BITS;

	logic [7:0]                mem [DEPTH];
	logic [FIFO_ADDR_BITS-1:0] wr_ptr;
	logic [FIFO_ADDR_BITS-1:0] rd_ptr;
	logic [FIFO_ADDR_BITS-1:0] level;
	logic [1:0]                strobe_s;
	logic                      pop;

	// one slot stays free to tell full from empty
	assign level   = wr_ptr - rd_ptr;
	assign avail_o = (wr_ptr != rd_ptr);
	assign full_o  = (level == FIFO_ADDR_BITS'(DEPTH - 1));
	assign data_o  = mem[rd_ptr];

	assign pop = strobe_s[0] & ~strobe_s[1] & avail_o;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			strobe_s <= 2'b00;
		end else begin
			strobe_s <= {strobe_s[0], strobe_i};
			if (push_i && !full_o)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (push_i && !full_o)
			mem[wr_ptr] <= data_i;
	end

	// fill level never wraps between empty and full in one step
	no_underrun: assert property (@(posedge clk) disable iff (reset)
		(level == '0) |=> (level != '1));
	no_overrun: assert property (@(posedge clk) disable iff (reset)
		(level == '1) |=> (level != '0));

endmodule

// ==== verilog/mfp.sv ====
// mfp peripheral top on the 8-bit cpu bus
// decodes register accesses, holds the port registers and muxes read data

`timescale 1ns/10ps

module mfp import mfp_pkg::*; #(
	parameter int FIFO_ADDR_BITS = 4
) (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] din_i,
	input  logic       sel_i,
	input  logic [4:0] addr_i,
	input  logic       ds_i,
	input  logic       rw_i,
	output logic [7:0] dout_o,
	output logic       irq_o,
	input  logic       iack_i,
	output logic       serial_avail_o,
	input  logic       serial_strobe_i,
	output logic [7:0] serial_data_o,
	input  logic       clk_ext_i,
	input  logic       de_i,
	input  logic       dma_irq_i,
	input  logic       acia_irq_i,
	input  logic       blitter_irq_i,
	input  logic       mono_detect_i
);

	mfp_reg_e    reg_addr;
	logic        bus_wr;
	logic        bus_rd;
	logic [7:0]  gpip;
	logic [7:0]  aer;
	logic [7:0]  ddr;
	logic [7:0]  vr;
	logic [7:0]  gpip_in;
	logic [7:0]  gpip_rd;
	logic [3:0]  ta_ctrl, tb_ctrl, tc_ctrl, td_ctrl;
	logic [7:0]  ta_dat, tb_dat, tc_dat, td_dat;
	logic        ta_done, tb_done, tc_done, td_done;
	logic [7:0]  irq_vec;
	logic [15:0] ier, ipr, isr, imr;
	logic        fifo_full;

	assign reg_addr = mfp_reg_e'(addr_i);
	assign bus_wr   = sel_i && !ds_i && !rw_i;
	assign bus_rd   = sel_i && !ds_i && rw_i;

	// the irq lines are active high here, inverted to look like the st port
	assign gpip_in = {mono_detect_i, 1'b0, ~dma_irq_i, ~acia_irq_i, ~blitter_irq_i, 3'b000};
	assign gpip_rd = (gpip_in & ~ddr) | (gpip & ddr);

	always_ff @(posedge clk) begin
		if (reset) begin
			gpip <= 8'h00;
			aer  <= 8'h00;
			ddr  <= 8'h00;
			vr   <= 8'h00;
		end else if (bus_wr) begin
			case (reg_addr)
				REG_GPIP: gpip <= din_i;
				REG_AER:  aer  <= din_i;
				REG_DDR:  ddr  <= din_i;
				REG_VR:   vr   <= din_i;
				default:  ;
			endcase
		end
	end

	// timer a has no event pin wired in this system
	mfp_timer #(.HAS_EVENT(1'b1)) timer_a (
		.clk(clk), .reset(reset), .xclk_i(clk_ext_i), .t_i(1'b0),
		.ctrl_i(din_i[3:0]), .ctrl_we_i(bus_wr && reg_addr == REG_TACR),
		.dat_i(din_i), .dat_we_i(bus_wr && reg_addr == REG_TADR),
		.ctrl_o(ta_ctrl), .dat_o(ta_dat), .done_o(ta_done)
	);

	// timer b counts display enable edges
	mfp_timer #(.HAS_EVENT(1'b1)) timer_b (
		.clk(clk), .reset(reset), .xclk_i(clk_ext_i), .t_i(de_i),
		.ctrl_i(din_i[3:0]), .ctrl_we_i(bus_wr && reg_addr == REG_TBCR),
		.dat_i(din_i), .dat_we_i(bus_wr && reg_addr == REG_TBDR),
		.ctrl_o(tb_ctrl), .dat_o(tb_dat), .done_o(tb_done)
	);

	// c and d share one control register
	mfp_timer #(.HAS_EVENT(1'b0)) timer_c (
		.clk(clk), .reset(reset), .xclk_i(clk_ext_i), .t_i(1'b0),
		.ctrl_i({1'b0, din_i[6:4]}), .ctrl_we_i(bus_wr && reg_addr == REG_TCDCR),
		.dat_i(din_i), .dat_we_i(bus_wr && reg_addr == REG_TCDR),
		.ctrl_o(tc_ctrl), .dat_o(tc_dat), .done_o(tc_done)
	);

	mfp_timer #(.HAS_EVENT(1'b0)) timer_d (
		.clk(clk), .reset(reset), .xclk_i(clk_ext_i), .t_i(1'b0),
		.ctrl_i({1'b0, din_i[2:0]}), .ctrl_we_i(bus_wr && reg_addr == REG_TCDCR),
		.dat_i(din_i), .dat_we_i(bus_wr && reg_addr == REG_TDDR),
		.ctrl_o(td_ctrl), .dat_o(td_dat), .done_o(td_done)
	);

	mfp_irq_ctrl irq_ctrl (
		.clk(clk), .reset(reset), .we_i(bus_wr), .addr_i(reg_addr), .din_i(din_i),
		.vr_i(vr), .timer_done_i({td_done, tc_done, tb_done, ta_done}),
		.dma_irq_i(dma_irq_i), .acia_irq_i(acia_irq_i), .blitter_irq_i(blitter_irq_i),
		.iack_i(iack_i), .irq_o(irq_o), .vec_o(irq_vec),
		.ier_o(ier), .ipr_o(ipr), .isr_o(isr), .imr_o(imr)
	);

	mfp_uart_fifo #(.FIFO_ADDR_BITS(FIFO_ADDR_BITS)) uart_fifo (
		.clk(clk), .reset(reset),
		.push_i(bus_wr && reg_addr == REG_UDR), .data_i(din_i),
		.strobe_i(serial_strobe_i), .avail_o(serial_avail_o),
		.full_o(fifo_full), .data_o(serial_data_o)
	);

	always_comb begin
		dout_o = 8'h00;
		if (bus_rd) begin
			case (reg_addr)
				REG_GPIP:  dout_o = gpip_rd;
				REG_AER:   dout_o = aer;
				REG_DDR:   dout_o = ddr;
				REG_IERA:  dout_o = ier[15:8];
				REG_IERB:  dout_o = ier[7:0];
				REG_IPRA:  dout_o = ipr[15:8];
				REG_IPRB:  dout_o = ipr[7:0];
				REG_ISRA:  dout_o = isr[15:8];
				REG_ISRB:  dout_o = isr[7:0];
				REG_IMRA:  dout_o = imr[15:8];
				REG_IMRB:  dout_o = imr[7:0];
				REG_VR:    dout_o = vr;
				REG_TACR:  dout_o = {4'h0, ta_ctrl};
				REG_TBCR:  dout_o = {4'h0, tb_ctrl};
				REG_TCDCR: dout_o = {tc_ctrl, td_ctrl};
				REG_TADR:  dout_o = ta_dat;
				REG_TBDR:  dout_o = tb_dat;
				REG_TCDR:  dout_o = tc_dat;
				REG_TDDR:  dout_o = td_dat;
				// tx buffer empty means there is room for another byte
				REG_TSR:   dout_o = fifo_full ? 8'h00 : 8'h80;
				default:   dout_o = 8'h00;
			endcase
		end else if (iack_i) begin
			dout_o = irq_vec;
		end
	end

endmodule

// ==== dv/mfp_tb.sv ====
// directed testbench for the mfp peripheral
// covers cpu register access, timers a and b, interrupt priority and the tx FIFO

`timescale 1ns/10ps

module mfp_tb import mfp_pkg::*; ();

	localparam int FIFO_ADDR_BITS = 4;
	localparam int FIFO_USABLE    = (1 << FIFO_ADDR_BITS) - 1;
	// clk cycles per clk_ext period
	localparam int XCLK_PERIOD    = 10;

	logic       clk, reset;
	logic       sel_i, ds_i, rw_i, iack_i;
	logic [4:0] addr_i;
	logic [7:0] din_i, dout_o;
	logic       irq_o;
	logic       serial_avail_o, serial_strobe_i;
	logic [7:0] serial_data_o;
	logic       clk_ext_i, de_i, mono_detect_i;
	logic       dma_irq_i, acia_irq_i, blitter_irq_i;

	logic [15:0] lfsr;
	string       cur_test;
	int          test_errs;
	int          tests_passed;
	int          tests_failed;

	mfp #(.FIFO_ADDR_BITS(FIFO_ADDR_BITS)) mfp_inst (
		.clk(clk), .reset(reset), .din_i(din_i), .sel_i(sel_i), .addr_i(addr_i),
		.ds_i(ds_i), .rw_i(rw_i), .dout_o(dout_o), .irq_o(irq_o), .iack_i(iack_i),
		.serial_avail_o(serial_avail_o), .serial_strobe_i(serial_strobe_i),
		.serial_data_o(serial_data_o), .clk_ext_i(clk_ext_i), .de_i(de_i),
		.dma_irq_i(dma_irq_i), .acia_irq_i(acia_irq_i), .blitter_irq_i(blitter_irq_i),
		.mono_detect_i(mono_detect_i)
	);

	always #4 clk = ~clk;

	// external timer clock toggles every 5 clk cycles
	always begin
		repeat (5) @(posedge clk);
		#1;
		clk_ext_i = ~clk_ext_i;
	end

	// taps 16, 14, 13, 11
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = 8'h00;
		for (int i = 0; i < n; i++)
			v = {v[6:0], lfsr_bit()};
		return v;
	endfunction

	task automatic check(input string what, input logic [15:0] exp, input logic [15:0] act);
		if (exp !== act) begin
			$display("mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		if (test_errs == 0) begin
			$display("test %s passed", cur_test);
			tests_passed++;
		end else begin
			$display("test %s failed with %0d errors", cur_test, test_errs);
			tests_failed++;
		end
	endtask

	task automatic bus_write(input mfp_reg_e addr, input logic [7:0] data);
		@(posedge clk);
		#1;
		sel_i = 1'b1;
		ds_i = 1'b0;
		rw_i = 1'b0;
		addr_i = addr;
		din_i = data;
		@(posedge clk);
		#1;
		sel_i = 1'b0;
		ds_i = 1'b1;
		rw_i = 1'b1;
	endtask

	task automatic bus_read(input mfp_reg_e addr, output logic [7:0] data);
		@(posedge clk);
		#1;
		sel_i = 1'b1;
		ds_i = 1'b0;
		rw_i = 1'b1;
		addr_i = addr;
		// read data is combinational and settles before the falling edge
		@(negedge clk);
		data = dout_o;
		@(posedge clk);
		#1;
		sel_i = 1'b0;
		ds_i = 1'b1;
	endtask

	task automatic acknowledge(output logic [7:0] vec);
		@(posedge clk);
		#1;
		iack_i = 1'b1;
		@(negedge clk);
		vec = dout_o;
		@(posedge clk);
		#1;
		iack_i = 1'b0;
	endtask

	task automatic wait_irq(input logic level, input int max_cycles);
		int n;
		n = 0;
		while (irq_o !== level && n < max_cycles) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (irq_o !== level) begin
			$display("timeout in %s: irq_o did not reach %0b within %0d cycles",
				cur_test, level, max_cycles);
			test_errs++;
		end
	endtask

	task automatic wait_avail_low(input int max_cycles);
		int n;
		n = 0;
		while (serial_avail_o !== 1'b0 && n < max_cycles) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (serial_avail_o !== 1'b0) begin
			$display("timeout in %s: serial_avail_o stayed high", cur_test);
			test_errs++;
		end
	endtask

	// polls a register over the bus until the bit is set
	task automatic wait_reg_bit(input mfp_reg_e addr, input int bit_idx, input int max_reads);
		logic [7:0] v;
		int n;
		bus_read(addr, v);
		n = 1;
		while (!v[bit_idx] && n < max_reads) begin
			bus_read(addr, v);
			n++;
		end
		if (!v[bit_idx]) begin
			$display("timeout in %s: register bit %0d never set", cur_test, bit_idx);
			test_errs++;
		end
	endtask

	task automatic pulse_de();
		@(posedge clk);
		#1;
		de_i = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		de_i = 1'b0;
		repeat (3) @(posedge clk);
		#1;
	endtask

	task automatic pulse_strobe();
		@(posedge clk);
		#1;
		serial_strobe_i = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		serial_strobe_i = 1'b0;
		repeat (3) @(posedge clk);
		#1;
	endtask

	task automatic write_readback(input mfp_reg_e addr);
		logic [7:0] d;
		logic [7:0] v;
		d = rand_bits(8);
		bus_write(addr, d);
		bus_read(addr, v);
		check($sformatf("readback of reg %h", addr), d, v);
	endtask

	task automatic reset_values();
		logic [7:0] v;
		start_test("reset_state");
		check("irq_o", 0, irq_o);
		check("serial_avail_o", 0, serial_avail_o);
		for (int a = REG_IERA; a <= REG_IMRB; a++) begin
			bus_read(mfp_reg_e'(a), v);
			check($sformatf("interrupt reg %h", a), 0, v);
		end
		bus_read(REG_TSR, v);
		check("tsr", 8'h80, v);
		end_test();
	endtask

	task automatic register_readback();
		logic [7:0] g, d, pins, v;
		start_test("register_access");
		write_readback(REG_IERA);
		write_readback(REG_IERB);
		write_readback(REG_IMRA);
		write_readback(REG_IMRB);
		write_readback(REG_VR);
		write_readback(REG_AER);
		write_readback(REG_DDR);
		@(posedge clk);
		#1;
		mono_detect_i = 1'b1;
		g = rand_bits(8);
		d = rand_bits(8);
		bus_write(REG_GPIP, g);
		bus_write(REG_DDR, d);
		// port pins carry mono at 7 and the inverted irq lines at 5, 4 and 3
		pins = {mono_detect_i, 1'b0, ~dma_irq_i, ~acia_irq_i, ~blitter_irq_i, 3'b000};
		bus_read(REG_GPIP, v);
		check("gpip with ddr mix", (pins & ~d) | (g & d), v);
		bus_write(REG_DDR, 8'h00);
		bus_write(REG_IERA, 8'h00);
		bus_write(REG_IERB, 8'h00);
		bus_write(REG_IMRA, 8'h00);
		bus_write(REG_IMRB, 8'h00);
		end_test();
	endtask

	task automatic timer_a_delay();
		logic [7:0] vr_val, mask, v, vec;
		int limit;
		start_test("timer_a_delay");
		vr_val = rand_bits(4) << 4;
		mask = 8'h01 << (IRQ_TIMER_A - 8);
		bus_write(REG_VR, vr_val);
		bus_write(REG_IERA, mask);
		bus_write(REG_IMRA, mask);
		bus_write(REG_TADR, 8'd3);
		bus_write(REG_TACR, 8'(TM_DELAY_4));
		bus_read(REG_TADR, v);
		check("count at or below load", 1, v <= 8'd3);
		limit = (3 * prescale_div(TM_DELAY_4) + 4) * XCLK_PERIOD;
		wait_irq(1'b1, limit);
		acknowledge(vec);
		check("vector", {vr_val[7:4], IRQ_TIMER_A}, vec);
		bus_read(REG_IPRA, v);
		check("ipr bit after ack", 0, v & mask);
		bus_write(REG_TACR, 8'(TM_STOP));
		bus_write(REG_IERA, 8'h00);
		bus_write(REG_IMRA, 8'h00);
		end_test();
	endtask

	task automatic timer_b_event();
		logic [7:0] mask, v;
		int n;
		start_test("timer_b_event");
		n = 2 + rand_bits(3);
		mask = 8'h01 << (IRQ_TIMER_B - 8);
		bus_write(REG_IERA, mask);
		bus_write(REG_TBDR, 8'(n));
		bus_write(REG_TBCR, 8'(TM_EVENT));
		for (int i = 0; i < n - 1; i++)
			pulse_de();
		bus_read(REG_IPRA, v);
		check("ipr after n-1 edges", 0, v & mask);
		pulse_de();
		wait_reg_bit(REG_IPRA, IRQ_TIMER_B - 8, 8);
		// writing zero clears pending and the reloaded count must run again
		bus_write(REG_IPRA, ~mask);
		for (int i = 0; i < n - 1; i++)
			pulse_de();
		bus_read(REG_IPRA, v);
		check("ipr after reload and n-1 edges", 0, v & mask);
		bus_write(REG_TBCR, 8'(TM_STOP));
		bus_write(REG_IERA, 8'h00);
		end_test();
	endtask

	task automatic priority_in_service();
		logic [7:0] vr_val, mask, v, vec;
		start_test("priority_in_service");
		vr_val = (rand_bits(4) << 4) | 8'h08;
		mask = (8'h01 << IRQ_DMA) | (8'h01 << IRQ_BLITTER);
		bus_write(REG_VR, vr_val);
		bus_write(REG_IERB, mask);
		bus_write(REG_IMRB, mask);
		@(posedge clk);
		#1;
		dma_irq_i = 1'b1;
		blitter_irq_i = 1'b1;
		wait_irq(1'b1, 20);
		acknowledge(vec);
		check("first vector", {vr_val[7:4], IRQ_DMA}, vec);
		bus_read(REG_ISRB, v);
		check("isr after first ack", 8'h01 << IRQ_DMA, v);
		check("irq_o while dma in service", 0, irq_o);
		bus_write(REG_ISRB, ~(8'h01 << IRQ_DMA));
		wait_irq(1'b1, 20);
		acknowledge(vec);
		check("second vector", {vr_val[7:4], IRQ_BLITTER}, vec);
		@(posedge clk);
		#1;
		dma_irq_i = 1'b0;
		blitter_irq_i = 1'b0;
		bus_write(REG_ISRB, 8'h00);
		bus_write(REG_IERB, 8'h00);
		bus_write(REG_IMRB, 8'h00);
		bus_write(REG_VR, 8'h00);
		end_test();
	endtask

	task automatic uart_fifo_drain();
		logic [7:0] q [$];
		logic [7:0] v, b;
		int pushed;
		start_test("uart_fifo");
		pushed = 0;
		bus_read(REG_TSR, v);
		while (v != 8'h00 && pushed < FIFO_USABLE + 4) begin
			b = rand_bits(8);
			bus_write(REG_UDR, b);
			q.push_back(b);
			pushed++;
			bus_read(REG_TSR, v);
		end
		check("bytes until full", FIFO_USABLE, pushed);
		// this one is dropped
		bus_write(REG_UDR, rand_bits(8));
		bus_read(REG_TSR, v);
		check("tsr when full", 0, v);
		check("serial_avail_o when full", 1, serial_avail_o);
		while (q.size() > 0) begin
			b = q.pop_front();
			check("serial data", b, serial_data_o);
			pulse_strobe();
		end
		wait_avail_low(20);
		end_test();
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		sel_i = 1'b0;
		ds_i = 1'b1;
		rw_i = 1'b1;
		addr_i = 5'h00;
		din_i = 8'h00;
		iack_i = 1'b0;
		serial_strobe_i = 1'b0;
		clk_ext_i = 1'b0;
		de_i = 1'b0;
		dma_irq_i = 1'b0;
		acia_irq_i = 1'b0;
		blitter_irq_i = 1'b0;
		mono_detect_i = 1'b0;
		lfsr = 16'd57355;
		tests_passed = 0;
		tests_failed = 0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		reset_values();
		register_readback();
		timer_a_delay();
		timer_b_event();
		priority_in_service();
		uart_fifo_drain();

		$display("tests passed %0d failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// ==== mfp_subsys.f ====
verilog/mfp_pkg.sv
verilog/mfp_timer.sv
verilog/mfp_irq_ctrl.sv
verilog/mfp_uart_fifo.sv
verilog/mfp.sv
dv/mfp_tb.sv

// ==== Bender.yml ====
package:
  name: mfp_subsys

sources:
  - files:
      - verilog/mfp_pkg.sv
      - verilog/mfp_timer.sv
      - verilog/mfp_irq_ctrl.sv
      - verilog/mfp_uart_fifo.sv
      - verilog/mfp.sv
  - target: test
    files:
      - dv/mfp_tb.sv
